// ==== test/bridgeTestdata.mem ====
// ctrl (write flag nibble, htrans nibble), address, data (write data or expected read), gap
// gap ff means a random gap of 0 to 3 idle cycles, ctrl ff ends the list
12 80000000 11111111 02
02 80000000 11111111 02
02 84000010 7bffffef 01
12 84000010 22222222 00
13 84000014 33333333 00
13 88000020 44444444 00
12 8bfffffc 55555555 02
02 84000014 33333333 00
02 88000020 44444444 01
12 8c000000 66666666 01
02 7ffffffc 00000000 01
10 80000100 77777777 01
01 80000104 00000000 01
12 80000200 88888888 00
02 80000200 88888888 ff
12 83fffffc 99999999 ff
02 83fffffc 99999999 ff
12 80000200 aaaaaaaa 00
13 80000204 bbbbbbbb 00
02 80000200 aaaaaaaa ff
02 80000204 bbbbbbbb 00
02 8bfffffc 55555555 02
ff 00000000 00000000 00

// ==== filelist.f ====
verilog/ahbApbPkg.sv
verilog/ahbPipeIf.sv
verilog/ahbSlaveInterface.sv
verilog/apbFsmController.sv
verilog/ahbApbBridge.sv
test/ahbApbBridge_asserts.sv
test/ahbApbBridgeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module ahbApbBridgeTb -o bridgeSim

# assertion errors are counted by the testbench, so the run must not stop at the first one
status=0
./obj_dir/bridgeSim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "TEST PASSED" sim.log && [ "$status" -eq 0 ]; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== test/ahbApbBridgeTb.sv ====
// Testbench for the AHB to APB bridge with an AHB master, APB memory model, scoreboard and watchdog.
module ahbApbBridgeTb;
	import ahbApbPkg::*;

	typedef struct packed {
		logic wr;
		logic [AddrWidth-1:0] addr;
		logic [DataWidth-1:0] data;
		logic [SelWidth-1:0] sel;
	} apbAccess;

	logic Hclk = 1'b0;
	logic Hresetn;
	logic Hwrite;
	logic Hreadyin;
	logic [1:0] Htrans;
	logic [AddrWidth-1:0] Haddr;
	logic [DataWidth-1:0] Hwdata;
	logic [DataWidth-1:0] Prdata;
	logic [DataWidth-1:0] Hrdata;
	logic [1:0] Hresp;
	logic Hreadyout;
	logic [AddrWidth-1:0] Paddr;
	logic [DataWidth-1:0] Pwdata;
	logic Pwrite;
	logic Penable;
	logic [SelWidth-1:0] Pselx;

	logic [31:0] testData [0:127]; // four words per entry for ctrl, address, data and gap.
	logic [DataWidth-1:0] apbMem [logic [AddrWidth-1:0]];
	logic [DataWidth-1:0] shadowMem [logic [AddrWidth-1:0]];
	apbAccess expQ[$];
	int entryCount = 0;
	int expectedAccesses = 0;
	int accessCount = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	int seed = 32'h506f_563f;
	bit loaded = 1'b0;
	bit started = 1'b0;
	bit driveDone = 1'b0;
	int nextIdx = 0;
	int gapLeft = 0;
	int apIdx = 0;
	bit apActive = 1'b0;
	bit dpActive = 1'b0;
	bit dpCheck = 1'b0;
	logic [DataWidth-1:0] dpExp;

	assign Hreadyin = Hreadyout; // bridge is the only slave on the bus.

	ahbApbBridge DUT (.*);

	always #20 Hclk = ~Hclk;

	function automatic logic [SelWidth-1:0] windowOf(input logic [AddrWidth-1:0] addr);
		logic [SelWidth-1:0] sel;
		sel = '0;
		if (addr >= SlaveBase0 && addr < SlaveBase0 + SlaveSpan)
			sel[0] = 1'b1;
		if (addr >= SlaveBase1 && addr < SlaveBase1 + SlaveSpan)
			sel[1] = 1'b1;
		if (addr >= SlaveBase2 && addr < SlaveBase2 + SlaveSpan)
			sel[2] = 1'b1;
		return sel;
	endfunction

	function automatic bit entryValid(input int i);
		logic [1:0] trans;
		trans = testData[4*i][1:0];
		return (trans == HtransNonseq || trans == HtransSeq) && (windowOf(testData[4*i+1]) != '0);
	endfunction

	task automatic checkAddr(input logic [AddrWidth-1:0] actual, expected, input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("Fail %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic checkData(input logic [DataWidth-1:0] actual, expected, input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("Fail %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic checkSel(input logic [SelWidth-1:0] actual, expected, input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("Fail %0t: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic checkWrite(input logic actual, expected, input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("Fail %0t: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic checkResp(input logic [1:0] actual, expected, input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("Fail %0t: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	// build the expected APB accesses and the shadow copy of memory.
	task automatic loadTests();
		apbAccess acc;
		$readmemh("test/bridgeTestdata.mem", testData);
		while (4*entryCount+3 < 128 && testData[4*entryCount] != 32'hff)
		begin
			if (entryValid(entryCount))
			begin
				acc.wr = testData[4*entryCount][4];
				acc.addr = testData[4*entryCount+1];
				acc.data = testData[4*entryCount+2];
				acc.sel = windowOf(acc.addr);
				if (acc.wr)
					shadowMem[acc.addr] = acc.data;
				else if ((shadowMem.exists(acc.addr) ? shadowMem[acc.addr] : ~acc.addr) != acc.data)
				begin
					otherErrors++;
					$display("read expectation of entry %0d disagrees with earlier writes", entryCount);
				end
				expQ.push_back(acc);
				expectedAccesses++;
			end
			entryCount++;
		end
		loaded = 1'b1;
	endtask

	// AHB master whose address and data phases advance only while Hreadyout is high.
	always @(posedge Hclk)
	begin
		if (started && Hreadyout)
		begin
			if (dpActive)
				checkResp(Hresp, HrespOkay, "Hresp");
			if (dpActive && dpCheck)
				checkData(Hrdata, dpExp, "Hrdata");
			dpActive = 1'b0;
			if (apActive)
			begin
				dpActive = 1'b1;
				dpCheck = entryValid(apIdx) && !testData[4*apIdx][4];
				dpExp = testData[4*apIdx+2];
				if (testData[4*apIdx][4])
					Hwdata <= testData[4*apIdx+2];
			end
			apActive = 1'b0;
			if (gapLeft > 0 || nextIdx >= entryCount)
			begin
				Htrans <= HtransIdle;
				Hwrite <= 1'b0;
				Haddr <= '0;
				if (gapLeft > 0)
					gapLeft--;
				else if (!dpActive)
					driveDone = 1'b1;
			end
			else
			begin
				Htrans <= testData[4*nextIdx][1:0];
				Hwrite <= testData[4*nextIdx][4];
				Haddr <= testData[4*nextIdx+1];
				apActive = 1'b1;
				apIdx = nextIdx;
				if (testData[4*nextIdx+3][7:0] == 8'hff)
					gapLeft = $random(seed) & 3; // random idle gap.
				else
					gapLeft = int'(testData[4*nextIdx+3][7:0]);
				nextIdx++;
			end
		end
	end

	// APB memory model and scoreboard.
	always @(posedge Hclk)
	begin
		if (Hresetn && Pselx != '0)
		begin
			if (!Penable && !Pwrite)
				Prdata <= apbMem.exists(Paddr) ? apbMem[Paddr] : ~Paddr;
			if (Penable)
			begin
				accessCount++;
				if (Pwrite)
					apbMem[Paddr] = Pwdata;
				if (expQ.size() == 0)
				begin
					otherErrors++;
					$display("unexpected APB access at address %h, time %0t", Paddr, $time);
				end
				else
				begin
					checkAddr(Paddr, expQ[0].addr, "Paddr");
					checkSel(Pselx, expQ[0].sel, "Pselx");
					checkWrite(Pwrite, expQ[0].wr, "Pwrite");
					if (expQ[0].wr)
						checkData(Pwdata, expQ[0].data, "Pwdata");
					void'(expQ.pop_front());
				end
			end
		end
	end

	initial
	begin
		int waitCycles;
		int assertErrors;
		Hresetn = 1'b0;
		Hwrite = 1'b0;
		Htrans = HtransIdle;
		Haddr = '0;
		Hwdata = '0;
		Prdata = '0;
		loadTests();
		repeat (9) @(posedge Hclk);
		@(negedge Hclk);
		checkAddr(Paddr, '0, "Paddr in reset");
		checkData(Pwdata, '0, "Pwdata in reset");
		checkSel(Pselx, '0, "Pselx in reset");
		checkWrite(Penable, 1'b0, "Penable in reset");
		checkWrite(Hreadyout, 1'b0, "Hreadyout in reset");
		@(posedge Hclk);
		Hresetn <= 1'b1;
		waitCycles = 0;
		do
		begin
			@(negedge Hclk);
			waitCycles++;
		end
		while (!Hreadyout && waitCycles < 3);
		if (!Hreadyout || waitCycles > 2)
		begin
			otherErrors++;
			$display("Hreadyout did not rise within two cycles of reset release");
		end
		checkSel(Pselx, '0, "Pselx while idle");
		@(posedge Hclk);
		started <= 1'b1;
		while (!driveDone || expQ.size() != 0)
			@(negedge Hclk);
		repeat (4) @(negedge Hclk); // catch any extra accesses.
		if (accessCount != expectedAccesses)
		begin
			otherErrors++;
			$display("saw %0d APB accesses but expected %0d", accessCount, expectedAccesses);
		end
		assertErrors = DUT.protocolChecks.failCount;
		$display("errors: %0d value, %0d other, %0d assertion", valueErrors, otherErrors,
			assertErrors);
		if (valueErrors + otherErrors + assertErrors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog sized from the number of transfers.
	initial
	begin
		int limit;
		wait (loaded);
		limit = entryCount * 8 + 50 + 10;
		repeat (limit) @(posedge Hclk);
		$display("watchdog expired after %0d cycles, the bridge seems to hang", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== test/ahbApbBridge_asserts.sv ====
// APB protocol checks bound onto the bridge top level.
module ahbApbBridgeAsserts (
	input logic Hclk,
	input logic Hresetn,
	input logic Penable,
	input logic Hreadyout,
	input logic [ahbApbPkg::SelWidth-1:0] Pselx,
	input logic [ahbApbPkg::AddrWidth-1:0] Paddr
);
	import ahbApbPkg::*;

	int failCount = 0;

	// enable follows a setup cycle to the same peripheral and address.
	enableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> $past(Pselx != '0 && !Penable) && Pselx == $past(Pselx)
			&& Paddr == $past(Paddr))
	else
	begin
		$error("Penable without a matching setup cycle");
		failCount++;
	end

	selOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(Pselx))
	else
	begin
		$error("Pselx has more than one bit set");
		failCount++;
	end

	// the AHB side is stalled through every setup phase.
	readyLowInSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(Pselx != '0 && !Penable) |-> !Hreadyout)
	else
	begin
		$error("Hreadyout high during an APB setup cycle");
		failCount++;
	end

endmodule

bind ahbApbBridge ahbApbBridgeAsserts protocolChecks (
	.Hclk (Hclk),
	.Hresetn (Hresetn),
	.Penable (Penable),
	.Hreadyout (Hreadyout),
	.Pselx (Pselx),
	.Paddr (Paddr)
);

// ==== verilog/ahbApbBridge.sv ====
// AHB-Lite to APB bridge top level joining the slave interface and the APB FSM.
module ahbApbBridge (
	input logic Hclk,
	input logic Hresetn,
	input logic Hwrite,
	input logic Hreadyin,
	input logic [1:0] Htrans,
	input logic [ahbApbPkg::AddrWidth-1:0] Haddr,
	input logic [ahbApbPkg::DataWidth-1:0] Hwdata,
	input logic [ahbApbPkg::DataWidth-1:0] Prdata,
	output logic [ahbApbPkg::DataWidth-1:0] Hrdata,
	output logic [1:0] Hresp,
	output logic Hreadyout,
	output logic [ahbApbPkg::AddrWidth-1:0] Paddr,
	output logic [ahbApbPkg::DataWidth-1:0] Pwdata,
	output logic Pwrite,
	output logic Penable,
	output logic [ahbApbPkg::SelWidth-1:0] Pselx
);
	import ahbApbPkg::*;

	ahbPipeIf pipe ();

	// Hreadyin is expected to be Hreadyout fed back by the bus.
	ahbSlaveInterface slaveSide (
		.Hclk (Hclk),
		.Hresetn (Hresetn),
		.Hwrite (Hwrite),
		.Hreadyin (Hreadyin),
		.Htrans (Htrans),
		.Haddr (Haddr),
		.Hwdata (Hwdata),
		.pipe (pipe.slave)
	);

	apbFsmController apbFsm (
		.Hclk (Hclk),
		.Hresetn (Hresetn),
		.Hwrite (Hwrite),
		.Haddr (Haddr),
		.Hwdata (Hwdata),
		.pipe (pipe.ctrl),
		.Pwrite (Pwrite),
		.Penable (Penable),
		.Hreadyout (Hreadyout),
		.Pselx (Pselx),
		.Paddr (Paddr),
		.Pwdata (Pwdata)
	);

	assign Hrdata = Prdata; // sampled by the master while Hreadyout is high.
	assign Hresp = HrespOkay;

endmodule

// ==== verilog/apbFsmController.sv ====
// APB FSM: drives setup and enable phases and stretches AHB transfers through Hreadyout.
module apbFsmController (
	input logic Hclk,
	input logic Hresetn,
	input logic Hwrite,
	input logic [ahbApbPkg::AddrWidth-1:0] Haddr,
	input logic [ahbApbPkg::DataWidth-1:0] Hwdata,
	ahbPipeIf.ctrl pipe,
	output logic Pwrite,
	output logic Penable,
	output logic Hreadyout,
	output logic [ahbApbPkg::SelWidth-1:0] Pselx,
	output logic [ahbApbPkg::AddrWidth-1:0] Paddr,
	output logic [ahbApbPkg::DataWidth-1:0] Pwdata
);
	import ahbApbPkg::*;

	logic [2:0] presentState;
	logic [2:0] nextState;
	logic [SelWidth-1:0] selHeld; // window of the transfer in its data phase.

	logic pwriteNext;
	logic penableNext;
	logic hreadyoutNext;
	logic [SelWidth-1:0] pselxNext;
	logic [AddrWidth-1:0] paddrNext;
	logic [DataWidth-1:0] pwdataNext;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			presentState <= StIdle;
		else
			presentState <= nextState;
	end

	always_comb
	begin
		case (presentState)
			StIdle, StRenable, StWenable:
			begin
				if (!pipe.valid)
					nextState = StIdle;
				else if (Hwrite)
					nextState = StWwait;
				else
					nextState = StRead;
			end
			StWwait:
				nextState = pipe.valid ? StWriteP : StWrite;
			StRead:
				nextState = StRenable;
			StWrite:
				nextState = pipe.valid ? StWenableP : StWenable;
			StWriteP:
				nextState = StWenableP;
			StWenableP:
			begin
				// pending transfer decides, a read breaks the write pipeline.
				if (!pipe.Hwritereg)
					nextState = StRead;
				else if (pipe.valid)
					nextState = StWriteP;
				else
					nextState = StWrite;
			end
			default:
				nextState = StIdle;
		endcase
	end

	// select follows the address phase so write setups see the right window.
	always_ff @(posedge Hclk)
	begin
		if (pipe.valid)
			selHeld <= pipe.tempselx;
	end

	always_comb
	begin
		paddrNext = Paddr;
		pwdataNext = Pwdata;
		pwriteNext = Pwrite;
		pselxNext = Pselx;
		penableNext = Penable;
		hreadyoutNext = Hreadyout;
		case (presentState)
			StIdle, StRenable, StWenable:
			begin
				penableNext = 1'b0;
				if (pipe.valid && !Hwrite)
				begin
					paddrNext = Haddr; // read setup straight from the address phase.
					pwriteNext = 1'b0;
					pselxNext = pipe.tempselx;
					hreadyoutNext = 1'b0;
				end
				else
				begin
					pselxNext = '0;
					hreadyoutNext = 1'b1; // a write waits one cycle for its data.
				end
			end
			StWwait:
			begin
				paddrNext = pipe.Haddr1;
				pwdataNext = Hwdata;
				pwriteNext = 1'b1;
				pselxNext = selHeld;
				penableNext = 1'b0;
				hreadyoutNext = 1'b0;
			end
			StRead:
			begin
				penableNext = 1'b1;
				hreadyoutNext = 1'b1;
			end
			StWrite:
			begin
				penableNext = 1'b1;
				hreadyoutNext = !pipe.valid || Hwrite; // hold a read taken here.
			end
			StWriteP:
			begin
				penableNext = 1'b1;
				hreadyoutNext = pipe.Hwritereg; // pending read has no data yet.
			end
			StWenableP:
			begin
				// setup of the pending transfer right behind the enable.
				paddrNext = pipe.Haddr1;
				pwriteNext = pipe.Hwritereg;
				pselxNext = selHeld;
				penableNext = 1'b0;
				hreadyoutNext = 1'b0;
				if (pipe.Hwritereg)
					pwdataNext = Hwdata;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Paddr <= '0;
			Pwdata <= '0;
			Pwrite <= 1'b0;
			Pselx <= '0;
			Penable <= 1'b0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			Paddr <= paddrNext;
			Pwdata <= pwdataNext;
			Pwrite <= pwriteNext;
			Pselx <= pselxNext;
			Penable <= penableNext;
			Hreadyout <= hreadyoutNext;
		end
	end

endmodule

// ==== verilog/ahbSlaveInterface.sv ====
// AHB-Lite slave side that qualifies transfers, decodes the peripheral and pipelines the address.
module ahbSlaveInterface (
	input logic Hclk,
	input logic Hresetn,
	input logic Hwrite,
	input logic Hreadyin,
	input logic [1:0] Htrans,
	input logic [ahbApbPkg::AddrWidth-1:0] Haddr,
	input logic [ahbApbPkg::DataWidth-1:0] Hwdata,
	ahbPipeIf.slave pipe
);
	import ahbApbPkg::*;

	logic transActive;
	logic [SelWidth-1:0] selDecode;

	// only NONSEQ and SEQ carry a transfer.
	always_comb
	begin
		case (Htrans)
			HtransNonseq, HtransSeq: transActive = 1'b1;
			HtransIdle, HtransBusy: transActive = 1'b0;
		endcase
	end

	// window hit when the offset from the base is below the span.
	assign selDecode[0] = (Haddr - SlaveBase0) < SlaveSpan;
	assign selDecode[1] = (Haddr - SlaveBase1) < SlaveSpan;
	assign selDecode[2] = (Haddr - SlaveBase2) < SlaveSpan;

	assign pipe.tempselx = selDecode;

	// Hreadyin is the bus ready and equals Hreadyout when the bridge is the only slave.
	assign pipe.valid = Hreadyin && transActive && (|selDecode);

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			pipe.Hwritereg <= 1'b0;
		else if (Hreadyin)
			pipe.Hwritereg <= Hwrite;
	end

	always_ff @(posedge Hclk)
	begin
		if (Hreadyin)
			pipe.Haddr1 <= Haddr; // advances only when the address phase completes.
	end

endmodule

// ==== verilog/ahbPipeIf.sv ====
// Qualified and pipelined AHB transfer passed from the slave interface to the APB FSM.
interface ahbPipeIf;
	import ahbApbPkg::*;

	logic valid; // transfer accepted in this address phase.
	logic [AddrWidth-1:0] Haddr1; // address of the transfer in its data phase.
	logic Hwritereg; // its write flag.
	logic [SelWidth-1:0] tempselx; // one-hot window of the current Haddr.

	modport slave (
		output valid,
		output Haddr1,
		output Hwritereg,
		output tempselx
	);

	modport ctrl (
		input valid,
		input Haddr1,
		input Hwritereg,
		input tempselx
	);

endinterface

// ==== verilog/ahbApbPkg.sv ====
// Bridge package with bus widths, the peripheral address map, AHB codes and FSM states.
package ahbApbPkg;

	// bus widths.
	localparam int AddrWidth = 32;
	localparam int DataWidth = 32;
	localparam int SelWidth = 3;

	// three peripheral windows, each SlaveSpan bytes long.
	localparam logic [AddrWidth-1:0] SlaveBase0 = 32'h8000_0000;
	localparam logic [AddrWidth-1:0] SlaveBase1 = 32'h8400_0000;
	localparam logic [AddrWidth-1:0] SlaveBase2 = 32'h8800_0000;
	localparam logic [AddrWidth-1:0] SlaveSpan = 32'h0400_0000;

	// HTRANS encodings.
	localparam logic [1:0] HtransIdle = 2'b00;
	localparam logic [1:0] HtransBusy = 2'b01;
	localparam logic [1:0] HtransNonseq = 2'b10;
	localparam logic [1:0] HtransSeq = 2'b11;

	localparam logic [1:0] HrespOkay = 2'b00;

	// controller states.
	localparam logic [2:0] StIdle = 3'b000;
	localparam logic [2:0] StWwait = 3'b001;
	localparam logic [2:0] StRead = 3'b010;
	localparam logic [2:0] StWrite = 3'b011;
	localparam logic [2:0] StWriteP = 3'b100; // write setup with a transfer pending.
	localparam logic [2:0] StRenable = 3'b101;
	localparam logic [2:0] StWenable = 3'b110;
	localparam logic [2:0] StWenableP = 3'b111; // write enable with a transfer pending.

endpackage
